// ==== cab_pkg.sv ====
`default_nettype none

package cab_pkg;

	// Bit positions in the held-key bitmap
	typedef enum logic [3:0] {
		key_right     = 4'd0,
		key_left      = 4'd1,
		key_fire      = 4'd4,
		key_start     = 4'd5,
		key_coin      = 4'd7,
		key_gear_up   = 4'd10,
		key_gear_down = 4'd11
	} key_t;

	localparam int KEY_W = 12;
	localparam logic [KEY_W-1:0] KEY_USED = 12'hcb3; // Bits named in key_t

	// Host joystick word
	localparam int JOY_W         = 8;
	localparam int JOY_RIGHT     = 0;
	localparam int JOY_LEFT      = 1;
	localparam int JOY_FIRE      = 4;
	localparam int JOY_GEAR_UP   = 5;
	localparam int JOY_GEAR_DOWN = 6;

	typedef enum logic [1:0] {gear_1, gear_2, gear_3} gear_t;

	// Quadrature states in forward order
	typedef enum logic [1:0] {
		ph_00 = 2'b00,
		ph_01 = 2'b01,
		ph_11 = 2'b11,
		ph_10 = 2'b10
	} steer_phase_t;

	localparam int STEER_DIV = 22500; // Clocks per steering step
	localparam int STEER_CW  = $clog2(STEER_DIV);

endpackage

`default_nettype wire

// ==== cfg_pkg.sv ====
`default_nettype none

package cfg_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Register word addresses
	typedef enum logic [ADDR_W-1:0] {
		reg_status = 8'h00,
		reg_joy0   = 8'h04,
		reg_joy1   = 8'h08,
		reg_keys   = 8'h0c  // Read only
	} cfg_addr_t;

	localparam int STAT_RESET = 0;
	localparam int STAT_TEST  = 1;
	localparam int STAT_W     = 2;

	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} resp_t;

endpackage

`default_nettype wire

// ==== ps2_keyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard import cab_pkg::*; (
	input  logic             clk_24,
	input  logic             rst,
	input  logic             ps2_clk,
	input  logic             ps2_data,
	output logic [KEY_W-1:0] keys
);

	logic [2:0]  clk_sr;  // Two sync stages and one for the edge
	logic [1:0]  data_sr;
	logic        clk_fall;
	logic [10:0] frame;
	logic [10:0] frame_next;
	logic        frame_ok;
	logic [3:0]  bit_cnt;
	logic        rx_stb;
	logic [7:0]  rx_code;
	logic        brk;
	logic        ext;
	logic        hit;
	key_t        hit_key;

	always_ff @(posedge clk_24) begin
		if (rst) begin
			clk_sr  <= 3'b111;
			data_sr <= 2'b11;
		end else begin
			clk_sr  <= {clk_sr[1:0], ps2_clk};
			data_sr <= {data_sr[0], ps2_data};
		end
	end

	assign clk_fall   = clk_sr[2] & ~clk_sr[1];
	assign frame_next = {data_sr[1], frame[10:1]}; // LSB first
	// Start low, odd parity over data and parity, stop high
	assign frame_ok   = ~frame_next[0] & (^frame_next[9:1]) & frame_next[10];

	always_ff @(posedge clk_24) begin
		if (clk_fall) begin
			frame <= frame_next;
			if (bit_cnt == 4'd10)
				rx_code <= frame_next[8:1];
		end
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			bit_cnt <= '0;
			rx_stb  <= 1'b0;
		end else begin
			rx_stb <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt <= '0;
					rx_stb  <= frame_ok;
				end else if (bit_cnt != 4'd0 || !data_sr[1]) begin
					bit_cnt <= bit_cnt + 4'd1; // A high bit cannot open a frame
				end
			end
		end
	end

	// Scancode to bitmap position with E0 in bit 8
	always_comb begin
		hit     = 1'b1;
		hit_key = key_fire;
		case ({ext, rx_code})
			9'h174:  hit_key = key_right;
			9'h16b:  hit_key = key_left;
			9'h029:  hit_key = key_fire;
			9'h016:  hit_key = key_start;
			9'h02e:  hit_key = key_coin;
			9'h015:  hit_key = key_gear_up;
			9'h01c:  hit_key = key_gear_down;
			default: hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_24) begin
		if (rst) begin
			keys <= '0;
			brk  <= 1'b0;
			ext  <= 1'b0;
		end else if (rx_stb) begin
			if (rx_code == 8'hf0) begin
				brk <= 1'b1;
			end else if (rx_code == 8'he0) begin
				ext <= 1'b1;
			end else begin
				if (hit)
					keys[hit_key] <= ~brk;
				brk <= 1'b0;
				ext <= 1'b0;
			end
		end
	end

	a_keys_known: assert property (@(posedge clk_24) disable iff (rst)
		(keys & ~KEY_USED) == '0);

endmodule

`default_nettype wire

// ==== steer_quad.sv ====
`timescale 1ns/1ps
`default_nettype none

module steer_quad import cab_pkg::*; (
	input  logic clk_24,
	input  logic rst,
	input  logic right,
	input  logic left,
	output logic steer_a,
	output logic steer_b
);

	logic [1:0]          dir;
	logic [1:0]          dir_q;
	logic                held;
	logic [STEER_CW-1:0] cnt;
	steer_phase_t        phase;

	function automatic steer_phase_t step_fwd(input steer_phase_t p);
		case (p)
			ph_00:   return ph_01;
			ph_01:   return ph_11;
			ph_11:   return ph_10;
			default: return ph_00;
		endcase
	endfunction

	function automatic steer_phase_t step_back(input steer_phase_t p);
		case (p)
			ph_00:   return ph_10;
			ph_10:   return ph_11;
			ph_11:   return ph_01;
			default: return ph_00;
		endcase
	endfunction

	assign dir  = {right, left};
	assign held = right ^ left;

	always_ff @(posedge clk_24) begin
		if (rst) begin
			dir_q <= 2'b00;
			cnt   <= '0;
			phase <= ph_00;
		end else begin
			dir_q <= dir;
			if (!held || dir != dir_q) begin
				cnt <= STEER_CW'(1); // First step a full period after the press
			end else if (cnt == STEER_CW'(STEER_DIV - 1)) begin
				cnt   <= '0;
				phase <= right ? step_fwd(phase) : step_back(phase);
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign steer_a = phase[1];
	assign steer_b = phase[0];

	// Gray sequence at the pins
	a_one_bit_step: assert property (@(posedge clk_24) disable iff (rst)
		!($changed(steer_a) && $changed(steer_b)));

endmodule

`default_nettype wire

// ==== gear_shift.sv ====
`timescale 1ns/1ps
`default_nettype none

module gear_shift import cab_pkg::*; (
	input  logic clk_24,
	input  logic rst,
	input  logic gear_up,
	input  logic gear_down,
	output logic gear1_n,
	output logic gear2_n,
	output logic gear3_n
);

	logic  up_q;
	logic  down_q;
	logic  up_rise;
	logic  down_rise;
	gear_t gear;

	assign up_rise   = gear_up & ~up_q;
	assign down_rise = gear_down & ~down_q;

	always_ff @(posedge clk_24) begin
		if (rst) begin
			up_q   <= 1'b0;
			down_q <= 1'b0;
			gear   <= gear_1;
		end else begin
			up_q   <= gear_up;
			down_q <= gear_down;
			if (up_rise && !down_rise) begin
				case (gear)
					gear_1:  gear <= gear_2;
					default: gear <= gear_3; // Saturate
				endcase
			end else if (down_rise && !up_rise) begin
				case (gear)
					gear_3:  gear <= gear_2;
					default: gear <= gear_1;
				endcase
			end
		end
	end

	assign gear1_n = (gear != gear_1);
	assign gear2_n = (gear != gear_2);
	assign gear3_n = (gear != gear_3);

	a_one_gear: assert property (@(posedge clk_24) disable iff (rst)
		$onehot({~gear1_n, ~gear2_n, ~gear3_n}));

endmodule

`default_nettype wire

// ==== cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_regs import cab_pkg::*, cfg_pkg::*; (
	input  logic              clk_24,
	input  logic              rst,
	input  logic [ADDR_W-1:0] s_awaddr,
	input  logic              s_awvalid,
	output logic              s_awready,
	input  logic [DATA_W-1:0] s_wdata,
	input  logic [STRB_W-1:0] s_wstrb,
	input  logic              s_wvalid,
	output logic              s_wready,
	output logic [1:0]        s_bresp,
	output logic              s_bvalid,
	input  logic              s_bready,
	input  logic [ADDR_W-1:0] s_araddr,
	input  logic              s_arvalid,
	output logic              s_arready,
	output logic [DATA_W-1:0] s_rdata,
	output logic [1:0]        s_rresp,
	output logic              s_rvalid,
	input  logic              s_rready,
	input  logic [KEY_W-1:0]  keys,
	output logic [JOY_W-1:0]  joy0,
	output logic [JOY_W-1:0]  joy1,
	output logic              test_mode,
	output logic              core_reset
);

	typedef enum logic {wr_idle, wr_resp} wr_state_t;
	typedef enum logic {rd_idle, rd_resp} rd_state_t;

	wr_state_t         wr_state;
	rd_state_t         rd_state;
	logic              wr_go;
	logic              rd_go;
	logic [STAT_W-1:0] status;
	logic [DATA_W-1:0] wmask;

	function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [DATA_W-1:0] mask);
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	always_comb begin
		for (int i = 0; i < STRB_W; i++)
			wmask[i*8 +: 8] = {8{s_wstrb[i]}};
	end

	assign wr_go = s_awready & s_awvalid & s_wready & s_wvalid;
	assign rd_go = s_arready & s_arvalid;

	// **************************************************
	// Write channel
	// **************************************************
	always_ff @(posedge clk_24) begin
		if (rst) begin
			wr_state  <= wr_idle;
			s_awready <= 1'b0;
			s_wready  <= 1'b0;
			s_bvalid  <= 1'b0;
			status    <= '0;
			joy0      <= '0;
			joy1      <= '0;
		end else begin
			case (wr_state)
				wr_idle: begin
					if (wr_go) begin
						s_awready <= 1'b0;
						s_wready  <= 1'b0;
						s_bvalid  <= 1'b1;
						s_bresp   <= resp_okay;
						wr_state  <= wr_resp;
						case (s_awaddr)
							reg_status: status <= STAT_W'(merge(DATA_W'(status), s_wdata, wmask));
							reg_joy0:   joy0 <= JOY_W'(merge(DATA_W'(joy0), s_wdata, wmask));
							reg_joy1:   joy1 <= JOY_W'(merge(DATA_W'(joy1), s_wdata, wmask));
							default:    s_bresp <= resp_slverr; // Keys or unmapped
						endcase
					end else begin
						// Address and data accepted together
						s_awready <= s_awvalid & s_wvalid;
						s_wready  <= s_awvalid & s_wvalid;
					end
				end
				default: begin
					if (s_bready) begin
						s_bvalid <= 1'b0;
						wr_state <= wr_idle;
					end
				end
			endcase
		end
	end

	// **************************************************
	// Read channel
	// **************************************************
	always_ff @(posedge clk_24) begin
		if (rst) begin
			rd_state  <= rd_idle;
			s_arready <= 1'b0;
			s_rvalid  <= 1'b0;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (rd_go) begin
						s_arready <= 1'b0;
						s_rvalid  <= 1'b1;
						s_rresp   <= resp_okay;
						rd_state  <= rd_resp;
						case (s_araddr)
							reg_status: s_rdata <= DATA_W'(status);
							reg_joy0:   s_rdata <= DATA_W'(joy0);
							reg_joy1:   s_rdata <= DATA_W'(joy1);
							reg_keys:   s_rdata <= DATA_W'(keys);
							default: begin
								s_rdata <= '0;
								s_rresp <= resp_slverr;
							end
						endcase
					end else begin
						s_arready <= s_arvalid;
					end
				end
				default: begin
					if (s_rready) begin
						s_rvalid <= 1'b0;
						rd_state <= rd_idle;
					end
				end
			endcase
		end
	end

	assign test_mode  = status[STAT_TEST];
	assign core_reset = status[STAT_RESET];

	a_bvalid_hold: assert property (@(posedge clk_24) disable iff (rst)
		s_bvalid && !s_bready |=> s_bvalid);

	a_rdata_stable: assert property (@(posedge clk_24) disable iff (rst)
		s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata));

endmodule

`default_nettype wire

// ==== sd_dac.sv ====
`timescale 1ns/1ps
`default_nettype none

module sd_dac (
	input  logic       clk_24,
	input  logic       rst,
	input  logic [6:0] audio,
	output logic       audio_out
);

	logic [7:0] acc; // Bit 7 holds the carry

	always_ff @(posedge clk_24) begin
		if (rst) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= {1'b0, acc[6:0]} + {1'b0, audio};
			audio_out <= acc[7];
		end
	end

endmodule

`default_nettype wire

// ==== cabinet_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module cabinet_io import cab_pkg::*, cfg_pkg::*; (
	input  logic              clk_24,
	input  logic              rst,
	input  logic [ADDR_W-1:0] s_awaddr,
	input  logic              s_awvalid,
	output logic              s_awready,
	input  logic [DATA_W-1:0] s_wdata,
	input  logic [STRB_W-1:0] s_wstrb,
	input  logic              s_wvalid,
	output logic              s_wready,
	output logic [1:0]        s_bresp,
	output logic              s_bvalid,
	input  logic              s_bready,
	input  logic [ADDR_W-1:0] s_araddr,
	input  logic              s_arvalid,
	output logic              s_arready,
	output logic [DATA_W-1:0] s_rdata,
	output logic [1:0]        s_rresp,
	output logic              s_rvalid,
	input  logic              s_rready,
	input  logic              ps2_clk,
	input  logic              ps2_data,
	input  logic [6:0]        audio,
	output logic              audio_out,
	output logic              coin_n,
	output logic              start_n,
	output logic              gas_n,
	output logic              gear1_n,
	output logic              gear2_n,
	output logic              gear3_n,
	output logic              test_n,
	output logic              steer_a,
	output logic              steer_b,
	output logic              core_reset
);

	logic [KEY_W-1:0] keys;
	logic [JOY_W-1:0] joy0;
	logic [JOY_W-1:0] joy1;
	logic             test_mode;
	logic             m_right;
	logic             m_left;
	logic             m_gear_up;
	logic             m_gear_down;

	// **************************************************
	// Control merge of keyboard and both joysticks
	// **************************************************
	assign m_right     = keys[key_right] | joy0[JOY_RIGHT] | joy1[JOY_RIGHT];
	assign m_left      = keys[key_left] | joy0[JOY_LEFT] | joy1[JOY_LEFT];
	assign m_gear_up   = keys[key_gear_up] | joy0[JOY_GEAR_UP] | joy1[JOY_GEAR_UP];
	assign m_gear_down = keys[key_gear_down] | joy0[JOY_GEAR_DOWN] | joy1[JOY_GEAR_DOWN];

	assign gas_n   = ~(keys[key_fire] | joy0[JOY_FIRE] | joy1[JOY_FIRE]);
	assign start_n = ~keys[key_start];   // Keyboard only
	assign coin_n  = ~keys[key_coin];
	assign test_n  = ~test_mode;

	ps2_keyboard u_ps2_keyboard (
		.clk_24   (clk_24),
		.rst      (rst),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.keys     (keys)
	);

	steer_quad u_steer_quad (
		.clk_24  (clk_24),
		.rst     (rst),
		.right   (m_right),
		.left    (m_left),
		.steer_a (steer_a),
		.steer_b (steer_b)
	);

	gear_shift u_gear_shift (
		.clk_24    (clk_24),
		.rst       (rst),
		.gear_up   (m_gear_up),
		.gear_down (m_gear_down),
		.gear1_n   (gear1_n),
		.gear2_n   (gear2_n),
		.gear3_n   (gear3_n)
	);

	cfg_regs u_cfg_regs (
		.clk_24     (clk_24),
		.rst        (rst),
		.s_awaddr   (s_awaddr),
		.s_awvalid  (s_awvalid),
		.s_awready  (s_awready),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.s_wvalid   (s_wvalid),
		.s_wready   (s_wready),
		.s_bresp    (s_bresp),
		.s_bvalid   (s_bvalid),
		.s_bready   (s_bready),
		.s_araddr   (s_araddr),
		.s_arvalid  (s_arvalid),
		.s_arready  (s_arready),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rvalid   (s_rvalid),
		.s_rready   (s_rready),
		.keys       (keys),
		.joy0       (joy0),
		.joy1       (joy1),
		.test_mode  (test_mode),
		.core_reset (core_reset)
	);

	sd_dac u_sd_dac (
		.clk_24    (clk_24),
		.rst       (rst),
		.audio     (audio),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

// ==== tb_cabinet_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cabinet_io import cab_pkg::*, cfg_pkg::*; ();

	localparam int TIMEOUT  = 2000;
	localparam int PS2_HALF = 40; // System cycles per PS/2 half period

	logic              clk_24;
	logic              rst;
	logic [ADDR_W-1:0] s_awaddr;
	logic              s_awvalid;
	logic              s_awready;
	logic [DATA_W-1:0] s_wdata;
	logic [STRB_W-1:0] s_wstrb;
	logic              s_wvalid;
	logic              s_wready;
	logic [1:0]        s_bresp;
	logic              s_bvalid;
	logic              s_bready;
	logic [ADDR_W-1:0] s_araddr;
	logic              s_arvalid;
	logic              s_arready;
	logic [DATA_W-1:0] s_rdata;
	logic [1:0]        s_rresp;
	logic              s_rvalid;
	logic              s_rready;
	logic              ps2_clk;
	logic              ps2_data;
	logic [6:0]        audio;
	logic              audio_out;
	logic              coin_n;
	logic              start_n;
	logic              gas_n;
	logic              gear1_n;
	logic              gear2_n;
	logic              gear3_n;
	logic              test_n;
	logic              steer_a;
	logic              steer_b;
	logic              core_reset;
	logic [31:0]       rng;
	logic [1:0]        resp;

	cabinet_io u_cabinet_io (.*);

	initial begin
		clk_24 = 1'b0;
		forever #2 clk_24 = ~clk_24;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else
			abort_run($sformatf("** Error [%s] expected 0x%0h, got 0x%0h", name, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic tick();
		@(posedge clk_24);
		#1;
	endtask

	task automatic stall(); // Random 0..3 cycle back-pressure
		rng = xorshift32(rng);
		repeat (rng[1:0]) tick();
	endtask

	// **************************************************
	// AXI4-Lite master
	// **************************************************
	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		output logic [1:0] bresp_out);
		int n;
		s_awaddr  = addr;
		s_wdata   = data;
		s_wstrb   = '1;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		n = 0;
		while (!(s_awready && s_wready)) begin
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout: write address and data were never accepted");
		end
		tick(); // Transfer edge
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		stall();
		s_bready = 1'b1;
		n = 0;
		while (!s_bvalid) begin
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout: no write response");
		end
		bresp_out = s_bresp;
		tick();
		s_bready = 1'b0;
	endtask

	task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output logic [1:0] rresp_out);
		int n;
		s_araddr  = addr;
		s_arvalid = 1'b1;
		n = 0;
		while (!s_arready) begin
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout: read address was never accepted");
		end
		tick();
		s_arvalid = 1'b0;
		stall();
		s_rready = 1'b1;
		n = 0;
		while (!s_rvalid) begin
			tick();
			n++;
			if (n > TIMEOUT)
				abort_run("Timeout: no read data");
		end
		data      = s_rdata;
		rresp_out = s_rresp;
		tick();
		s_rready = 1'b0;
	endtask

	task automatic write_ok(input string name, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		logic [1:0] r;
		axi_write(addr, data, r);
		check_eq({name, " bresp"}, 32'(resp_okay), 32'(r));
	endtask

	task automatic read_check(input string name, input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] expected);
		logic [DATA_W-1:0] d;
		logic [1:0]        r;
		axi_read(addr, d, r);
		check_eq({name, " rresp"}, 32'(resp_okay), 32'(r));
		check_eq(name, expected, d);
	endtask

	// **************************************************
	// PS/2 device side
	// **************************************************
	task automatic ps2_send(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0}; // Stop, odd parity, data, start
		for (int i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			repeat (PS2_HALF) tick();
			ps2_clk = 1'b0;
			repeat (PS2_HALF) tick();
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
		repeat (PS2_HALF) tick();
	endtask

	task automatic key_make(input logic [7:0] code, input logic ext);
		if (ext)
			ps2_send(8'he0, 1'b0);
		ps2_send(code, 1'b0);
	endtask

	task automatic key_break(input logic [7:0] code, input logic ext);
		if (ext)
			ps2_send(8'he0, 1'b0);
		ps2_send(8'hf0, 1'b0);
		ps2_send(code, 1'b0);
	endtask

	// Waits for the next quadrature change; period 0 skips the interval check
	task automatic expect_step(input string name, input logic [1:0] expected, input int period);
		logic [1:0] prev;
		int         n;
		prev = {steer_a, steer_b};
		n = 0;
		while ({steer_a, steer_b} == prev) begin
			tick();
			n++;
			if (n > STEER_DIV + 4000)
				abort_run("Timeout: steering outputs stopped stepping");
		end
		check_eq(name, 32'(expected), 32'({steer_a, steer_b}));
		if (period != 0)
			check_eq({name, " period"}, period, n);
	endtask

	task automatic audio_check(input logic [6:0] level);
		int ones;
		audio = level;
		repeat (4) tick(); // Let the new level reach the pin
		ones = 0;
		repeat (128) begin
			tick();
			ones += int'(audio_out);
		end
		check_eq($sformatf("audio ones for %0d", level), 32'(level), ones);
	endtask

	a_ready_pair: assert property (@(posedge clk_24) disable iff (rst)
		s_awready == s_wready)
		else abort_run("s_awready and s_wready were not raised together");

	a_bvalid_next: assert property (@(posedge clk_24) disable iff (rst)
		s_awvalid && s_awready |=> s_bvalid)
		else abort_run("No write response in the cycle after acceptance");

	a_rvalid_next: assert property (@(posedge clk_24) disable iff (rst)
		s_arvalid && s_arready |=> s_rvalid)
		else abort_run("No read data in the cycle after acceptance");

	initial begin
		rst       = 1'b1;
		s_awaddr  = '0;
		s_awvalid = 1'b0;
		s_wdata   = '0;
		s_wstrb   = '0;
		s_wvalid  = 1'b0;
		s_bready  = 1'b0;
		s_araddr  = '0;
		s_arvalid = 1'b0;
		s_rready  = 1'b0;
		ps2_clk   = 1'b1;
		ps2_data  = 1'b1;
		audio     = '0;
		rng       = 32'd10398;
		repeat (10) @(posedge clk_24);
		#1;
		rst = 1'b0;
		tick();

		check_eq("reset core_reset", 32'h0, 32'(core_reset));
		check_eq("reset test_n", 32'h1, 32'(test_n));
		check_eq("reset gear", 32'h3, 32'({gear1_n, gear2_n, gear3_n}));
		check_eq("reset steer", 32'h0, 32'({steer_a, steer_b}));
		check_eq("reset audio_out", 32'h0, 32'(audio_out));

		// Registers
		read_check("status after reset", reg_status, 32'h0);
		write_ok("status write", reg_status, 32'h3);
		check_eq("core_reset set", 32'h1, 32'(core_reset));
		check_eq("test_n low", 32'h0, 32'(test_n));
		read_check("status read-back", reg_status, 32'h3);
		axi_write(reg_keys, 32'hfff, resp);
		check_eq("keys write bresp", 32'(resp_slverr), 32'(resp));
		axi_write(8'h10, 32'h1, resp);
		check_eq("unmapped write bresp", 32'(resp_slverr), 32'(resp));
		write_ok("status clear", reg_status, 32'h0);
		check_eq("core_reset clear", 32'h0, 32'(core_reset));
		check_eq("test_n clear", 32'h1, 32'(test_n));

		// Keyboard
		key_make(8'h29, 1'b0);
		key_make(8'h16, 1'b0);
		key_make(8'h2e, 1'b0);
		check_eq("space gas_n", 32'h0, 32'(gas_n));
		check_eq("1 start_n", 32'h0, 32'(start_n));
		check_eq("5 coin_n", 32'h0, 32'(coin_n));
		read_check("keys held", reg_keys, 32'h0b0); // Bits 4, 5 and 7
		key_break(8'h29, 1'b0);
		key_break(8'h16, 1'b0);
		key_break(8'h2e, 1'b0);
		check_eq("space released", 32'h1, 32'(gas_n));
		check_eq("1 released", 32'h1, 32'(start_n));
		check_eq("5 released", 32'h1, 32'(coin_n));
		ps2_send(8'h29, 1'b1);
		check_eq("bad parity gas_n", 32'h1, 32'(gas_n));
		read_check("keys after bad parity", reg_keys, 32'h0);

		// **************************************************
		// Steering forward on the right arrow and back on joystick 1 left
		// **************************************************
		key_make(8'h74, 1'b1);
		expect_step("right step 1", 2'b01, 0);
		expect_step("right step 2", 2'b11, STEER_DIV);
		expect_step("right step 3", 2'b10, STEER_DIV);
		expect_step("right step 4", 2'b00, STEER_DIV);
		key_break(8'h74, 1'b1);
		write_ok("joy1 left", reg_joy1, 32'h2);
		expect_step("left step 1", 2'b10, 0);
		expect_step("left step 2", 2'b11, STEER_DIV);
		expect_step("left step 3", 2'b01, STEER_DIV);
		expect_step("left step 4", 2'b00, STEER_DIV);
		write_ok("joy1 clear", reg_joy1, 32'h0);

		// Gears
		key_make(8'h15, 1'b0);
		key_break(8'h15, 1'b0);
		check_eq("gear up 1", 32'h5, 32'({gear1_n, gear2_n, gear3_n}));
		key_make(8'h15, 1'b0);
		key_break(8'h15, 1'b0);
		check_eq("gear up 2", 32'h6, 32'({gear1_n, gear2_n, gear3_n}));
		key_make(8'h15, 1'b0);
		key_break(8'h15, 1'b0);
		check_eq("gear up saturate", 32'h6, 32'({gear1_n, gear2_n, gear3_n}));
		write_ok("joy0 down", reg_joy0, 32'h40);
		write_ok("joy0 clear", reg_joy0, 32'h0);
		check_eq("gear down 1", 32'h5, 32'({gear1_n, gear2_n, gear3_n}));
		write_ok("joy0 down", reg_joy0, 32'h40);
		write_ok("joy0 clear", reg_joy0, 32'h0);
		check_eq("gear down 2", 32'h3, 32'({gear1_n, gear2_n, gear3_n}));
		write_ok("joy0 down", reg_joy0, 32'h40);
		write_ok("joy0 clear", reg_joy0, 32'h0);
		check_eq("gear down saturate", 32'h3, 32'({gear1_n, gear2_n, gear3_n}));

		// Audio
		audio_check(7'd0);
		audio_check(7'd37);
		audio_check(7'd127);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
cab_pkg.sv
cfg_pkg.sv
ps2_keyboard.sv
steer_quad.sv
gear_shift.sv
cfg_regs.sv
sd_dac.sv
cabinet_io.sv
tb_cabinet_io.sv

// ==== Makefile ====
SRCS := $(shell cat flist.f)

obj_dir/Vtb_cabinet_io: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_cabinet_io -f flist.f

run: obj_dir/Vtb_cabinet_io
	./obj_dir/Vtb_cabinet_io | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
